// ==== rtl/bus_consts.svh ====
`ifndef BUS_CONSTS_SVH
`define BUS_CONSTS_SVH

// target select, cpu_addr[16:15]
`define BRAM_SELECT_CONTROLLER 2'd0
`define BRAM_SELECT_MOD        2'd1
`define BRAM_SELECT_PWE_TABLE  2'd2

// controller registers, word addresses
`define ADDR_MOD_CTL        14'h0020  // bit 0 start, bit 1 read segment
`define ADDR_MOD_CYCLE      14'h0021  // last sample index
`define ADDR_MOD_FREQ_DIV   14'h0022  // clocks per sample, 0 acts as 1
`define ADDR_MOD_WR_SEGMENT 14'h0023  // segment taking mod writes

// two samples per word
`define MOD_SEG_WORDS 128
`define PWE_WORDS     128

`endif

// ==== rtl/bus_pkg.sv ====
package bus_pkg;

  typedef logic [16:0] cpu_addr_t;   // byte address
  typedef logic [15:0] bus_data_t;
  typedef logic [1:0]  bram_sel_t;
  typedef logic [13:0] bram_addr_t;  // word address

  // one decoded write
  typedef struct packed {
    bram_sel_t  sel;
    bram_addr_t addr;
    bus_data_t  data;
    logic       valid;
  } bus_wr_t;

endpackage

// ==== rtl/memory_bus_decode.sv ====
module memory_bus_decode
  import bus_pkg::*;
(
  input  logic      CPU_CKIO,
  input  logic      rst,
  input  cpu_addr_t cpu_addr,
  input  bus_data_t cpu_data,
  input  logic      cpu_cn,
  input  logic      cpu_we0_n,
  output bus_wr_t   bus_wr
);

  cpu_addr_t addr_q;
  bus_data_t data_q;
  logic      wr_q;
  logic      wr_qq;

  // address and data are set up before the strobe
  always_ff @(posedge CPU_CKIO) begin
    addr_q <= cpu_addr;
    data_q <= cpu_data;
  end

  always_ff @(posedge CPU_CKIO) begin
    if (rst) begin
      wr_q  <= 1'b0;
      wr_qq <= 1'b0;
    end else begin
      wr_q  <= ~cpu_we0_n & ~cpu_cn;
      wr_qq <= wr_q;
    end
  end

  assign bus_wr.sel   = addr_q[16:15];
  assign bus_wr.addr  = addr_q[14:1];
  assign bus_wr.data  = data_q;
  assign bus_wr.valid = wr_q & ~wr_qq;  // leading edge of the strobe only

  // address and data hold while the strobe stays low
  assert property (@(posedge CPU_CKIO) disable iff (rst)
                   !cpu_cn && !cpu_we0_n && $past(!cpu_cn && !cpu_we0_n) |->
                   $stable(cpu_addr) && $stable(cpu_data))
    else $error("cpu bus address or data changed during a write strobe");

endmodule

// ==== rtl/mod_ctrl_regs.sv ====
`include "bus_consts.svh"

module mod_ctrl_regs
  import bus_pkg::*;
  import mod_pkg::*;
(
  input  logic          CPU_CKIO,
  input  logic          rst,
  input  bus_wr_t       bus_wr,
  output mod_settings_t settings
);

  logic sel_ctrl;

  assign sel_ctrl = bus_wr.valid && (bus_wr.sel == `BRAM_SELECT_CONTROLLER);

  always_ff @(posedge CPU_CKIO) begin
    if (rst) begin
      settings <= '0;  // stopped, segment 0
    end else if (sel_ctrl) begin
      case (bus_wr.addr)
        `ADDR_MOD_CTL: begin
          settings.start          <= bus_wr.data[0];
          settings.req_rd_segment <= bus_wr.data[1];
        end
        `ADDR_MOD_CYCLE: begin
          settings.cycle <= bus_wr.data[7:0];
        end
        `ADDR_MOD_FREQ_DIV: begin
          settings.freq_div <= bus_wr.data;
        end
        `ADDR_MOD_WR_SEGMENT: begin
          settings.wr_segment <= bus_wr.data[0];
        end
        default: begin
          // unmapped address, dropped
        end
      endcase
    end
  end

endmodule

// ==== rtl/mod_memory.sv ====
`include "bus_consts.svh"

module mod_memory
  import bus_pkg::*;
  import mod_pkg::*;
(
  input  logic        CPU_CKIO,
  input  bus_wr_t     bus_wr,
  input  logic        wr_segment,
  input  logic        rd_segment,
  input  sample_idx_t rd_idx,
  output sample_t     sample
);

  // low byte holds the even sample
  bus_data_t mem[2][`MOD_SEG_WORDS];
  bus_data_t rd_word;
  logic      wr_en;

  assign wr_en = bus_wr.valid && (bus_wr.sel == `BRAM_SELECT_MOD) &&
                 (bus_wr.addr < `MOD_SEG_WORDS);

  always_ff @(posedge CPU_CKIO) begin
    if (wr_en) begin
      mem[wr_segment][bus_wr.addr[6:0]] <= bus_wr.data;
    end
  end

  assign rd_word = mem[rd_segment][rd_idx[7:1]];

  always_ff @(posedge CPU_CKIO) begin
    sample <= rd_idx[0] ? rd_word[15:8] : rd_word[7:0];
  end

endmodule

// ==== rtl/mod_pkg.sv ====
package mod_pkg;

  typedef logic [7:0]  sample_t;
  typedef logic [7:0]  pulse_width_t;
  typedef logic [7:0]  sample_idx_t;
  typedef logic [15:0] freq_div_t;

  typedef struct packed {
    logic        start;
    logic        req_rd_segment;  // taken at the next wrap
    logic        wr_segment;
    sample_idx_t cycle;           // last index of the loop
    freq_div_t   freq_div;
  } mod_settings_t;

  typedef struct packed {
    pulse_width_t pulse_width;
    sample_idx_t  idx;
    logic         segment;
  } mod_out_t;

  typedef enum logic [2:0] {
    st_idle,
    st_wait_tick,
    st_fetch,
    st_lookup,
    st_req_high,
    st_wait_ack_low
  } sampler_state_t;

endpackage

// ==== rtl/mod_sampler.sv ====
module mod_sampler
  import mod_pkg::*;
(
  input  logic          CPU_CKIO,
  input  logic          rst,
  input  mod_settings_t settings,
  output sample_idx_t   rd_idx,
  output logic          rd_segment,
  input  sample_t       sample,
  output sample_t       lookup,
  input  pulse_width_t  pulse_width,
  output logic          req,
  input  logic          ack,
  output mod_out_t      mod_out
);

  sampler_state_t state;
  freq_div_t      tmr;        // clocks since the last fetch
  freq_div_t      period_m1;
  logic           expired;
  sample_idx_t    idx;
  logic           seg;
  sample_t        sample_q;

  assign period_m1 = (settings.freq_div == '0) ? '0 : settings.freq_div - 1'b1;
  assign expired   = (tmr >= period_m1);

  always_ff @(posedge CPU_CKIO) begin
    if (rst) begin
      state <= st_idle;
      tmr   <= '0;
      idx   <= '0;
      seg   <= 1'b0;
    end else begin
      if (!expired) tmr <= tmr + 1'b1;  // saturates at expiry
      case (state)
        st_idle: begin
          if (settings.start) begin
            idx   <= '0;
            seg   <= settings.req_rd_segment;
            tmr   <= '0;
            state <= st_fetch;
          end
        end
        st_wait_tick: begin
          if (!settings.start) begin
            state <= st_idle;
          end else if (expired) begin
            tmr   <= '0;
            state <= st_fetch;
          end
        end
        st_fetch:  state <= st_lookup;
        st_lookup: state <= st_req_high;
        st_req_high: begin
          if (ack) begin
            if (idx >= settings.cycle) begin
              idx <= '0;
              seg <= settings.req_rd_segment;  // segment switch only at wrap
            end else begin
              idx <= idx + 1'b1;
            end
            state <= st_wait_ack_low;
          end
        end
        st_wait_ack_low: begin
          if (!ack) begin
            if (!settings.start) begin
              state <= st_idle;
            end else if (expired) begin
              tmr   <= '0;
              state <= st_fetch;
            end else begin
              state <= st_wait_tick;
            end
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // hold the table address through the handshake
  always_ff @(posedge CPU_CKIO) begin
    if (state == st_lookup) sample_q <= sample;
  end

  assign lookup     = (state == st_lookup) ? sample : sample_q;
  assign rd_idx     = idx;
  assign rd_segment = seg;
  assign req        = (state == st_req_high);

  assign mod_out.pulse_width = pulse_width;
  assign mod_out.idx         = idx;
  assign mod_out.segment     = seg;

  // consumer drops ack before the next request
  assert property (@(posedge CPU_CKIO) disable iff (rst) $rose(req) |-> !ack)
    else $error("req rose while ack still high");

  // a table write during req would show up here
  assert property (@(posedge CPU_CKIO) disable iff (rst) req && $past(req) |-> $stable(mod_out))
    else $error("mod_out changed while req high");

endmodule

// ==== rtl/mod_top.sv ====
module mod_top
  import bus_pkg::*;
  import mod_pkg::*;
(
  input  logic      CPU_CKIO,
  input  logic      rst,
  input  cpu_addr_t cpu_addr,
  input  bus_data_t cpu_data,
  input  logic      cpu_cn,
  input  logic      cpu_we0_n,
  input  logic      ack,
  output logic      req,
  output mod_out_t  mod_out
);

  bus_wr_t       bus_wr;
  mod_settings_t settings;
  sample_idx_t   rd_idx;
  logic          rd_segment;
  sample_t       sample;
  sample_t       lookup;
  pulse_width_t  pulse_width;

  memory_bus_decode u_decode (
    .CPU_CKIO, .rst, .cpu_addr, .cpu_data, .cpu_cn, .cpu_we0_n, .bus_wr
  );

  mod_ctrl_regs u_regs (.CPU_CKIO, .rst, .bus_wr, .settings);

  mod_memory u_mod_mem (
    .CPU_CKIO, .bus_wr, .wr_segment(settings.wr_segment), .rd_segment, .rd_idx, .sample
  );

  pwe_table u_pwe (.CPU_CKIO, .bus_wr, .lookup, .pulse_width);

  mod_sampler u_sampler (
    .CPU_CKIO, .rst, .settings, .rd_idx, .rd_segment, .sample, .lookup, .pulse_width,
    .req, .ack, .mod_out
  );

endmodule

// ==== rtl/pwe_table.sv ====
`include "bus_consts.svh"

module pwe_table
  import bus_pkg::*;
  import mod_pkg::*;
(
  input  logic         CPU_CKIO,
  input  bus_wr_t      bus_wr,
  input  sample_t      lookup,
  output pulse_width_t pulse_width
);

  bus_data_t table_mem[`PWE_WORDS];  // two entries per word
  bus_data_t rd_word;
  logic      wr_en;

  assign wr_en = bus_wr.valid && (bus_wr.sel == `BRAM_SELECT_PWE_TABLE) &&
                 (bus_wr.addr < `PWE_WORDS);

  always_ff @(posedge CPU_CKIO) begin
    if (wr_en) begin
      table_mem[bus_wr.addr[6:0]] <= bus_wr.data;
    end
  end

  assign rd_word = table_mem[lookup[7:1]];

  always_ff @(posedge CPU_CKIO) begin
    pulse_width <= lookup[0] ? rd_word[15:8] : rd_word[7:0];
  end

endmodule

// ==== run.sh ====
#!/bin/sh
# compile and run the modulation playback testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing -Wno-fatal --top-module tb_mod_top -f tb.f

out=$(./obj_dir/Vtb_mod_top)
echo "$out"

if echo "$out" | grep -qF '*** TEST PASSED ***'; then
  exit 0
fi
exit 1

// ==== tb.f ====
+incdir+rtl
rtl/bus_pkg.sv
rtl/mod_pkg.sv
rtl/memory_bus_decode.sv
rtl/mod_ctrl_regs.sv
rtl/mod_memory.sv
rtl/pwe_table.sv
rtl/mod_sampler.sv
rtl/mod_top.sv
verification/tb_mod_top.sv

// ==== verification/tb_mod_top.sv ====
`include "bus_consts.svh"

module tb_mod_top
  import bus_pkg::*;
  import mod_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  typedef struct packed {
    logic        seg;        // segment that gets fresh data
    sample_idx_t cycle;
    freq_div_t   fd;
    logic [31:0] seed;       // sample contents
    logic        do_switch;
    sample_idx_t sw_at;      // index held off for the segment switch
    logic [15:0] n;          // samples to collect
    logic [31:0] ack_mask;   // ack delay range
  } tcase_t;

  localparam int N_CASES = 5;

  logic      CPU_CKIO = 1'b0;
  logic      rst = 1'b1;
  cpu_addr_t cpu_addr = '0;
  bus_data_t cpu_data = '0;
  logic      cpu_cn = 1'b1;
  logic      cpu_we0_n = 1'b1;
  logic      ack = 1'b0;
  logic      req;
  mod_out_t  mod_out;

  tcase_t       cases [N_CASES];
  pulse_width_t pwe_ref [256];
  sample_t      seg_ref [2][256];
  logic         table_ready = 1'b0;
  logic         stopped = 1'b1;
  logic         hold_ack = 1'b0;
  logic         sw_pending = 1'b0;
  sample_idx_t  sw_at = '0;
  sample_idx_t  exp_idx = '0;
  logic         exp_seg = 1'b0;
  logic         cur_rd_seg = 1'b0;
  sample_idx_t  cur_cycle = '0;
  int           cur_fd = 0;
  int           min_gap = 1;
  int           cur_n = 0;
  int           n_got = 0;
  logic [31:0]  cur_mask = '0;
  logic [31:0]  ack_rng = 32'd68927;
  int           cyc = 0;
  int           last_rise = 0;
  logic         req_q = 1'b0;
  int           n_mismatch = 0;
  int           n_proto = 0;

  mod_top dut (
    .CPU_CKIO, .rst, .cpu_addr, .cpu_data, .cpu_cn, .cpu_we0_n, .ack, .req, .mod_out
  );

  always #20 CPU_CKIO = ~CPU_CKIO;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // address, data and cn first, then we low for two cycles
  task automatic bram_write(input bram_sel_t sel, input bram_addr_t addr, input bus_data_t data);
    @(posedge CPU_CKIO);
    cpu_addr <= {sel, addr, 1'b0};
    cpu_data <= data;
    cpu_cn   <= 1'b0;
    @(posedge CPU_CKIO);
    cpu_we0_n <= 1'b0;
    repeat (2) @(posedge CPU_CKIO);
    cpu_we0_n <= 1'b1;
    cpu_cn    <= 1'b1;
  endtask

  task automatic stop_sampler();
    bram_write(`BRAM_SELECT_CONTROLLER, `ADDR_MOD_CTL, {14'd0, cur_rd_seg, 1'b0});
    repeat (4) @(posedge CPU_CKIO);  // lets an in-flight fetch reach req
    while (req || ack) @(posedge CPU_CKIO);
    repeat (2) @(posedge CPU_CKIO);
    stopped = 1'b1;
  endtask

  // consumer side of the four-phase handshake
  always begin : ack_driver
    int unsigned d;
    @(posedge CPU_CKIO);
    if (req && !ack) begin
      if (sw_pending && mod_out.idx == sw_at) begin
        sw_pending = 1'b0;
        hold_ack = 1'b1;
        while (hold_ack) @(posedge CPU_CKIO);
      end
      ack_rng = xorshift(ack_rng);
      d = ack_rng & cur_mask;
      repeat (d) @(posedge CPU_CKIO);
      ack <= 1'b1;
      while (req) @(posedge CPU_CKIO);
      ack <= 1'b0;
    end
  end

  always @(posedge CPU_CKIO) begin : monitor
    pulse_width_t exp_pw;
    if (cyc > 0 && (rst || stopped)) begin
      assert (req === 1'b0) else begin
        n_proto++;
        $display("req high at %0d ns while in reset or stopped", $time);
      end
    end
    if (req && !req_q) begin
      assert (!ack) else begin
        n_proto++;
        $display("req rose at %0d ns while ack was still high", $time);
      end
      if (n_got < cur_n) begin
        if (n_got > 0) begin
          assert (cyc - last_rise >= min_gap) else begin
            n_mismatch++;
            $display("MISMATCH @%0t: req spacing %0d below %0d", $time, cyc - last_rise, min_gap);
          end
          if (cur_mask == 0 && cur_fd >= 8) begin  // spacing set by the timer alone
            assert (cyc - last_rise == cur_fd) else begin
              n_mismatch++;
              $display("MISMATCH @%0t: req spacing %0d, want %0d", $time, cyc - last_rise,
                       cur_fd);
            end
          end
        end
        exp_pw = pwe_ref[seg_ref[exp_seg][exp_idx]];
        assert (mod_out.idx == exp_idx && mod_out.segment == exp_seg &&
                mod_out.pulse_width == exp_pw) else begin
          n_mismatch++;
          $display("MISMATCH @%0t: got seg %0d idx %0d pw %02h, want seg %0d idx %0d pw %02h",
                   $time, mod_out.segment, mod_out.idx, mod_out.pulse_width,
                   exp_seg, exp_idx, exp_pw);
        end
        last_rise = cyc;
        n_got++;
        if (exp_idx == cur_cycle) begin
          exp_idx = '0;
          exp_seg = cur_rd_seg;  // read segment reloads at the wrap
        end else begin
          exp_idx++;
        end
      end
    end
    req_q = req;
    cyc++;
  end

  initial begin : main
    logic [31:0] rng;
    bus_data_t   w;
    cases[0] = '{1'b0, 8'd15, 16'd8, 32'h1234_5678, 1'b0, 8'd0, 16'd40, 32'd0};
    cases[1] = '{1'b0, 8'd255, 16'd0, 32'h0bad_f00d, 1'b0, 8'd0, 16'd300, 32'd7};
    cases[2] = '{1'b0, 8'd9, 16'd1, 32'h2468_ace1, 1'b0, 8'd0, 16'd30, 32'd7};
    cases[3] = '{1'b1, 8'd20, 16'd10, 32'h1357_9bdf, 1'b1, 8'd7, 16'd50, 32'd3};
    cases[4] = '{1'b0, 8'd5, 16'd12, 32'h5a5a_1234, 1'b0, 8'd0, 16'd14, 32'd0};
    table_ready = 1'b1;
    repeat (8) @(posedge CPU_CKIO);
    rst <= 1'b0;
    rng = 32'd68927;
    for (int i = 0; i < `PWE_WORDS; i++) begin
      rng = xorshift(rng);
      w = rng[15:0];
      bram_write(`BRAM_SELECT_PWE_TABLE, bram_addr_t'(i), w);
      pwe_ref[2*i]   = w[7:0];
      pwe_ref[2*i+1] = w[15:8];
    end
    for (int r = 0; r < N_CASES; r++) begin
      stop_sampler();
      bram_write(`BRAM_SELECT_CONTROLLER, `ADDR_MOD_WR_SEGMENT, {15'd0, cases[r].seg});
      rng = cases[r].seed;
      for (int i = 0; i < `MOD_SEG_WORDS; i++) begin
        rng = xorshift(rng);
        w = rng[15:0];
        bram_write(`BRAM_SELECT_MOD, bram_addr_t'(i), w);
        seg_ref[cases[r].seg][2*i]   = w[7:0];
        seg_ref[cases[r].seg][2*i+1] = w[15:8];
      end
      bram_write(`BRAM_SELECT_CONTROLLER, `ADDR_MOD_CYCLE, {8'd0, cases[r].cycle});
      bram_write(`BRAM_SELECT_CONTROLLER, `ADDR_MOD_FREQ_DIV, cases[r].fd);
      exp_idx    = '0;
      exp_seg    = 1'b0;
      cur_rd_seg = 1'b0;
      n_got      = 0;
      cur_cycle  = cases[r].cycle;
      cur_fd     = int'(cases[r].fd);
      min_gap    = (cur_fd == 0) ? 1 : cur_fd;
      cur_mask   = cases[r].ack_mask;
      sw_at      = cases[r].sw_at;
      sw_pending = cases[r].do_switch;
      cur_n      = int'(cases[r].n);
      stopped    = 1'b0;
      bram_write(`BRAM_SELECT_CONTROLLER, `ADDR_MOD_CTL, 16'h0001);
      while (n_got < cur_n) begin
        @(posedge CPU_CKIO);
        if (hold_ack) begin
          bram_write(`BRAM_SELECT_CONTROLLER, `ADDR_MOD_CTL, 16'h0003);  // read segment 1
          cur_rd_seg = 1'b1;
          hold_ack = 1'b0;
        end
      end
    end
    stop_sampler();
    $display("errors: %0d mismatches, %0d protocol", n_mismatch, n_proto);
    if (n_mismatch == 0 && n_proto == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  initial begin : watchdog
    longint unsigned limit;
    longint unsigned fd_eff;
    limit = 0;
    wait (table_ready);
    for (int r = 0; r < N_CASES; r++) begin
      fd_eff = (cases[r].fd == 0) ? 1 : longint'(cases[r].fd);
      limit += longint'(cases[r].n) * (fd_eff + 10 + longint'(cases[r].ack_mask));
    end
    limit += (N_CASES + 1) * 700 + 20;  // bus writes and reset
    #(limit * 40);
    $display("timeout: run did not finish within %0d ns", limit * 40);
    $display("errors: %0d mismatches, %0d protocol", n_mismatch, n_proto);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule
